//--- hdl/tree_route_pkg.sv
// tree sizes, address widths, hop direction enum, stage structs and digit helpers
`default_nettype none

package tree_route_pkg;

    // ====================
    // tree geometry
    // ====================
    localparam int k_ary       = 2;                  // children per router
    localparam int tree_levels = 3;                  // root is level 0
    localparam int kw          = 1;                  // bits per address digit
    localparam int addr_w      = tree_levels * kw;   // endpoint address
    localparam int lvl_w       = 2;                  // level number
    localparam int port_w      = 2;                  // 0..k_ary-1 down, k_ary up
    localparam int mask_w      = k_ary;              // request mask without arrival port

    typedef enum logic [1:0] {
        dir_down  = 2'd0,
        dir_up    = 2'd1,
        dir_eject = 2'd2
    } hop_dir_e;

    // ====================
    // stage payloads
    // ====================
    typedef struct packed {
        logic [addr_w-1:0] dest;
        logic [port_w-1:0] cur_port;  // port already picked here
    } route_req_t;

    typedef struct packed {
        logic [addr_w-1:0] dest;
        logic [lvl_w-1:0]  next_level;
        logic [addr_w-1:0] next_pos;     // digits left-aligned, low digits zero
        logic [port_w-1:0] arrive_port;  // port the flit enters the next router on
        logic              eject;
    } next_node_t;

    typedef struct packed {
        logic [addr_w-1:0] dest;
        logic [port_w-1:0] la_port;
        hop_dir_e          la_dir;
        logic [port_w-1:0] arrive_port;
        logic              eject;
    } la_route_t;

    typedef struct packed {
        logic [addr_w-1:0] dest;
        logic [port_w-1:0] la_port;
        hop_dir_e          la_dir;
        logic [mask_w-1:0] req_mask;
    } la_result_t;

    // digit d counted from the top, zero when out of range
    function automatic logic [kw-1:0] get_digit(input logic [addr_w-1:0] a, input int d);
        logic [kw-1:0] v;
        v = '0;
        if (d >= 0 && d < tree_levels) v = a[addr_w-1-d*kw -: kw];
        return v;
    endfunction

    function automatic logic [addr_w-1:0] set_digit(input logic [addr_w-1:0] a, input int d,
                                                    input logic [kw-1:0] v);
        logic [addr_w-1:0] r;
        r = a;
        if (d >= 0 && d < tree_levels) r[addr_w-1-d*kw -: kw] = v;
        return r;
    endfunction

    // ones over the top n digits
    function automatic logic [addr_w-1:0] top_mask(input int n);
        logic [addr_w-1:0] m;
        m = '0;
        for (int d = 0; d < tree_levels; d++) begin
            if (d < n) m[addr_w-1-d*kw -: kw] = '1;
        end
        return m;
    endfunction

endpackage

`default_nettype wire

//--- hdl/tree_next_hop.sv
// stage 1: neighbour behind the picked port, arrival port and eject flag, output register
`timescale 1ns/1ps
`default_nettype none

module tree_next_hop #(
    parameter int router_level = tree_route_pkg::tree_levels - 1,
    parameter int router_pos   = 0  // position value p, top digit first
) (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic                     in_valid,
    output logic                          in_ready,
    input  wire tree_route_pkg::route_req_t in_req,
    output logic                          nh_valid,
    input  wire logic                     nh_ready,
    output tree_route_pkg::next_node_t    nh
);

    import tree_route_pkg::*;

    logic [addr_w-1:0] cur_pos;  // this router, left-aligned
    next_node_t        nxt;

    assign cur_pos = addr_w'(router_pos << ((tree_levels - router_level) * kw));

    // ====================
    // neighbour rule
    // ====================
    always_comb begin
        nxt = '0;
        nxt.dest = in_req.dest;
        if (in_req.cur_port == port_w'(k_ary)) begin
            // up to (l-1, p div K), entering on p mod K
            nxt.next_level  = lvl_w'(router_level - 1);
            nxt.next_pos    = cur_pos & top_mask(router_level - 1);
            nxt.arrive_port = port_w'(get_digit(cur_pos, router_level - 1));
        end else if (router_level == tree_levels - 1) begin
            nxt.next_level  = lvl_w'(router_level);  // endpoint below a leaf
            nxt.next_pos    = cur_pos;
            nxt.arrive_port = in_req.cur_port;
            nxt.eject       = 1'b1;
        end else begin
            // down to (l+1, p*K+q), entering on the up port
            nxt.next_level  = lvl_w'(router_level + 1);
            nxt.next_pos    = set_digit(cur_pos, router_level, in_req.cur_port[kw-1:0]);
            nxt.arrive_port = port_w'(k_ary);
        end
    end

    // ====================
    // output register
    // ====================
    assign in_ready = ~nh_valid | nh_ready;  // empty or draining

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            nh_valid <= 1'b0;
        end else if (in_ready) begin
            nh_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            nh <= nxt;  // load on transfer only
        end
    end

endmodule

`default_nettype wire

//--- hdl/tree_nca_route.sv
// stage 2: nearest-common-ancestor route at the next router, output register
`timescale 1ns/1ps
`default_nettype none

module tree_nca_route (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic                     nh_valid,
    output logic                          nh_ready,
    input  wire tree_route_pkg::next_node_t nh,
    output logic                          la_valid,
    input  wire logic                     la_ready,
    output tree_route_pkg::la_route_t     la
);

    import tree_route_pkg::*;

    logic      below;  // dest lies under the next router
    la_route_t nxt;

    // top l' digits of dest against the next router position
    assign below = (nh.dest & top_mask(int'(nh.next_level))) == nh.next_pos;

    // ====================
    // route decision
    // ====================
    always_comb begin
        nxt = '0;
        nxt.dest        = nh.dest;
        nxt.arrive_port = nh.arrive_port;
        nxt.eject       = nh.eject;
        if (nh.eject) begin
            nxt.la_dir  = dir_eject;
            nxt.la_port = '0;
        end else if (below) begin
            nxt.la_dir  = dir_down;
            nxt.la_port = port_w'(get_digit(nh.dest, int'(nh.next_level)));  // child digit
        end else begin
            nxt.la_dir  = dir_up;
            nxt.la_port = port_w'(k_ary);
        end
    end

    // ====================
    // output register
    // ====================
    assign nh_ready = ~la_valid | la_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            la_valid <= 1'b0;
        end else if (nh_ready) begin
            la_valid <= nh_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (nh_valid && nh_ready) begin
            la <= nxt;
        end
    end

endmodule

`default_nettype wire

//--- hdl/tree_port_mask.sv
// stage 3: one-hot port decode, arrival port removal, output register
`timescale 1ns/1ps
`default_nettype none

module tree_port_mask (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    la_valid,
    output logic                         la_ready,
    input  wire tree_route_pkg::la_route_t la,
    output logic                         out_valid,
    input  wire logic                    out_ready,
    output tree_route_pkg::la_result_t   out_res
);

    import tree_route_pkg::*;

    logic [k_ary:0] port_oh;  // all K+1 ports
    la_result_t     nxt;

    always_comb begin
        port_oh = '0;
        if (la.la_port <= port_w'(k_ary)) port_oh[la.la_port] = 1'b1;
    end

    // drop the arrival port, shift the ports above it down by one
    always_comb begin
        nxt.dest    = la.dest;
        nxt.la_port = la.la_port;
        nxt.la_dir  = la.la_dir;
        for (int j = 0; j < mask_w; j++) begin
            if (port_w'(j) < la.arrive_port) nxt.req_mask[j] = port_oh[j];
            else nxt.req_mask[j] = port_oh[j+1];
        end
        if (la.eject) nxt.req_mask = '0;  // leaves the network
    end

    // ====================
    // output register
    // ====================
    assign la_ready = ~out_valid | out_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (la_ready) begin
            out_valid <= la_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (la_valid && la_ready) begin
            out_res <= nxt;
        end
    end

endmodule

`default_nettype wire

//--- hdl/tree_lookahead_router.sv
// top level of the look-ahead route pipeline: next hop, NCA route, port mask
`timescale 1ns/1ps
`default_nettype none

module tree_lookahead_router #(
    parameter int router_level = tree_route_pkg::tree_levels - 1,
    parameter int router_pos   = 0
) (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic                     in_valid,
    output logic                          in_ready,
    input  wire tree_route_pkg::route_req_t in_req,
    output logic                          out_valid,
    input  wire logic                     out_ready,
    output tree_route_pkg::la_result_t    out_res
);

    import tree_route_pkg::*;

    logic       nh_valid;
    logic       nh_ready;
    next_node_t nh;
    logic       la_valid;
    logic       la_ready;
    la_route_t  la;

    tree_next_hop #(
        .router_level (router_level),
        .router_pos   (router_pos)
    ) u_next_hop (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_req   (in_req),
        .nh_valid (nh_valid),
        .nh_ready (nh_ready),
        .nh       (nh)
    );

    tree_nca_route u_nca_route (
        .clk      (clk),
        .reset    (reset),
        .nh_valid (nh_valid),
        .nh_ready (nh_ready),
        .nh       (nh),
        .la_valid (la_valid),
        .la_ready (la_ready),
        .la       (la)
    );

    tree_port_mask u_port_mask (
        .clk       (clk),
        .reset     (reset),
        .la_valid  (la_valid),
        .la_ready  (la_ready),
        .la        (la),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_res   (out_res)
    );

endmodule

`default_nettype wire

//--- verif/tree_route_checker.sv
// expected result queue, output and in_ready comparison, latency check, error counts
`timescale 1ns/1ps
`default_nettype none

module tree_route_checker (
    input wire logic                       clk,
    input wire logic                       reset,
    input wire logic                       in_valid,
    input wire logic                       in_ready,
    input wire logic                       out_valid,
    input wire logic                       out_ready,
    input wire tree_route_pkg::la_result_t out_res
);

    import tree_route_pkg::*;

    la_result_t exp_q[$];
    int         accept_q[$];          // cycle number of each accepted request
    la_result_t exp_r;
    int         lat;
    int         cycle      = 0;
    int         checked    = 0;
    int         mismatches = 0;
    int         other_errs = 0;
    logic       latency_on = 1'b0;    // only with an idle pipeline and out_ready high

    task automatic push_expected(input la_result_t r);
        exp_q.push_back(r);
    endtask

    task automatic set_latency_check(input logic on);
        latency_on = on;
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    task automatic compare_field(input string name, input int expv, input int got);
        if (expv != got) begin
            $display("mismatch at %0t: %s expected %0h got %0h", $time, name, expv, got);
            mismatches++;
        end
    endtask

    // ====================
    // output watch
    // ====================
    always @(posedge clk) begin
        cycle++;
        if (reset) begin
            if (out_valid) begin
                $display("out_valid was high during reset at %0t", $time);
                other_errs++;
            end
        end else begin
            // ready drops only with three requests held and the output stalled
            compare_field("in_ready", (accept_q.size() == 3 && !out_ready) ? 0 : 1,
                          int'(in_ready));
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("a result came out at %0t with no request pending", $time);
                    other_errs++;
                end else begin
                    exp_r = exp_q.pop_front();
                    compare_field("out_res.dest", int'(exp_r.dest), int'(out_res.dest));
                    compare_field("out_res.la_port", int'(exp_r.la_port), int'(out_res.la_port));
                    compare_field("out_res.la_dir", int'(exp_r.la_dir), int'(out_res.la_dir));
                    compare_field("out_res.req_mask", int'(exp_r.req_mask),
                                  int'(out_res.req_mask));
                    lat = cycle - accept_q.pop_front();
                    if (latency_on) compare_field("latency", 3, lat);  // edge n to n+3
                    checked++;
                end
            end
            if (in_valid && in_ready) accept_q.push_back(cycle);
        end
    end

    function automatic int final_report(input int timeouts);
        if (exp_q.size() != 0) begin
            $display("%0d accepted requests never produced a result", exp_q.size());
            other_errs += exp_q.size();
        end
        $display("checked %0d results: %0d mismatches, %0d other errors, %0d timeouts",
                 checked, mismatches, other_errs, timeouts);
        return mismatches + other_errs + timeouts;
    endfunction

endmodule

`default_nettype wire

//--- verif/tree_lookahead_tb.sv
// testbench top: clock, reset, request table, LFSR back-pressure, driver and verdict
`timescale 1ns/1ps
`default_nettype none

module tree_lookahead_tb;

    import tree_route_pkg::*;

    typedef struct packed {
        route_req_t req;
        la_result_t res;
    } table_row_t;

    localparam int n_rows     = 16;
    localparam int wait_limit = 200;  // cycles per wait

    logic        clk          = 1'b0;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    route_req_t  in_req;
    logic        out_valid;
    logic        out_ready    = 1'b1;
    la_result_t  out_res;
    logic        random_ready;
    logic [15:0] lfsr         = 16'd19076;
    table_row_t  rows [n_rows];
    int          timeouts;
    int          total;

    tree_lookahead_router #(
        .router_level (2),
        .router_pos   (2)  // digits 1,0, parent is (1, 1)
    ) dut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_res   (out_res)
    );

    tree_route_checker u_checker (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_res   (out_res)
    );

    always #10 clk = ~clk;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic table_row_t make_row(input int dest, input int port, input int la_port,
                                            input hop_dir_e dir, input logic [mask_w-1:0] mask);
        table_row_t r;
        r.req.dest     = addr_w'(dest);
        r.req.cur_port = port_w'(port);
        r.res.dest     = addr_w'(dest);
        r.res.la_port  = port_w'(la_port);
        r.res.la_dir   = dir;
        r.res.req_mask = mask;
        return r;
    endfunction

    always @(posedge clk) begin
        #2;
        if (random_ready) begin
            out_ready = lfsr[0];  // one bit per step
            lfsr      = lfsr_step(lfsr);
        end else begin
            out_ready = 1'b1;
        end
    end

    // called at edge + 2, returns at edge + 2 with in_valid still high
    task automatic send_row(input table_row_t r);
        int waited;
        waited   = 0;
        in_req   = r.req;
        in_valid = 1'b1;
        #1;
        while (!in_ready && waited < wait_limit) begin
            @(posedge clk);
            #3;
            waited++;
        end
        if (in_ready) begin
            @(posedge clk);  // transfer edge
            u_checker.push_expected(r.res);
            #2;
        end else begin
            $display("in_ready stayed low for %0d cycles, dest %0d not sent", wait_limit,
                     r.req.dest);
            timeouts++;
            in_valid = 1'b0;
            @(posedge clk);
            #2;
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (u_checker.pending() != 0 && waited < wait_limit) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (u_checker.pending() != 0) begin
            $display("results still missing after %0d cycles of waiting", wait_limit);
            timeouts++;
        end
    endtask

    initial begin
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_req       = '0;
        random_ready = 1'b0;
        timeouts     = 0;
        // parent (1, 1) is entered on port 0
        rows[0]  = make_row(6, 2, 1, dir_down, 2'b01);
        rows[1]  = make_row(0, 2, 2, dir_up, 2'b10);
        rows[2]  = make_row(5, 0, 0, dir_eject, 2'b00);
        rows[3]  = make_row(4, 2, 0, dir_down, 2'b00);  // back down the arrival port
        rows[4]  = make_row(1, 1, 0, dir_eject, 2'b00);
        rows[5]  = make_row(7, 2, 1, dir_down, 2'b01);
        rows[6]  = make_row(3, 2, 2, dir_up, 2'b10);
        rows[7]  = make_row(2, 0, 0, dir_eject, 2'b00);
        rows[8]  = make_row(5, 2, 0, dir_down, 2'b00);
        rows[9]  = make_row(6, 1, 0, dir_eject, 2'b00);
        rows[10] = make_row(1, 2, 2, dir_up, 2'b10);
        rows[11] = make_row(0, 0, 0, dir_eject, 2'b00);
        rows[12] = make_row(2, 2, 2, dir_up, 2'b10);
        rows[13] = make_row(7, 1, 0, dir_eject, 2'b00);
        rows[14] = make_row(3, 0, 0, dir_eject, 2'b00);
        rows[15] = make_row(4, 1, 0, dir_eject, 2'b00);
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;

        // ====================
        // single request, idle pipeline
        // ====================
        @(posedge clk);
        #2;
        u_checker.set_latency_check(1'b1);
        send_row(rows[0]);
        in_valid = 1'b0;
        wait_drained();
        u_checker.set_latency_check(1'b0);

        // ====================
        // table under random back-pressure, then back to back
        // ====================
        random_ready = 1'b1;
        @(posedge clk);
        #2;
        foreach (rows[i]) send_row(rows[i]);
        in_valid = 1'b0;
        wait_drained();
        random_ready = 1'b0;
        @(posedge clk);
        #2;
        foreach (rows[i]) send_row(rows[i]);
        in_valid = 1'b0;
        wait_drained();

        total = u_checker.final_report(timeouts);
        if (total == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
hdl/tree_route_pkg.sv
hdl/tree_next_hop.sv
hdl/tree_nca_route.sv
hdl/tree_port_mask.sv
hdl/tree_lookahead_router.sv
verif/tree_route_checker.sv
verif/tree_lookahead_tb.sv

//--- Makefile
# Verilator build and run of the look-ahead router testbench

VERILATOR ?= verilator
TOP       ?= tree_lookahead_tb
BUILD_DIR ?= build
VFLAGS    ?= --binary --timescale 1ns/1ps -j 0

SOURCES := $(filter %.sv %.v,$(shell cat sources.f))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when the file list or a listed source changes
$(BIN): sources.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f sources.f

run: $(BIN)
	@$(BIN) | awk '{ print } $$0 == "TEST RESULT: PASS" { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)
